/* build.f */
+incdir+dv
src/fix_pkg.sv
src/fix_delim_scan.sv
src/fix_parser_out_module.sv
src/fix_field_assembler.sv
src/fix_field_fifo.sv
src/fix_parser_top.sv
dv/fix_parser_tb.sv

/* dv/fix_ref_model.svh */
`ifndef FIX_REF_MODEL_SVH
`define FIX_REF_MODEL_SVH

typedef logic [7:0] byte_q_t[$];
typedef field_t field_q_t[$];

// walks the stream one byte at a time as tag digits, '=', value bytes, SOH.
function automatic field_q_t parse_fields(input byte_q_t bs);
	field_q_t q;
	field_t   f;
	logic     in_val;
	logic     bad;
	logic     any;
	f      = '0;
	in_val = 1'b0;
	bad    = 1'b0;
	any    = 1'b0;
	foreach (bs[i]) begin
		if (bs[i] == SOH_CHAR) begin
			// a field counts only with a clean, nonempty tag.
			if (in_val && any && !bad) begin
				q.push_back(f);
			end
			f      = '0;
			in_val = 1'b0;
			bad    = 1'b0;
			any    = 1'b0;
		end else if (!in_val && bs[i] == SEP_CHAR) begin
			in_val = 1'b1;
		end else if (!in_val) begin
			if (bs[i] >= 8'h30 && bs[i] <= 8'h39) begin
				f.tag = tag_num_t'(f.tag * 10) + tag_num_t'(bs[i] - 8'h30);
				any   = 1'b1;
			end else begin
				bad = 1'b1;
			end
		end else begin
			f.value = {f.value[55:0], bs[i]};
			if (f.len == len_t'(VAL_MAX_BYTES)) begin
				f.trunc = 1'b1;
			end else begin
				f.len = f.len + 1'b1;
			end
		end
	end
	return q;
endfunction

`endif

/* dv/fix_parser_tb.sv */
`timescale 1ns/100ps
module fix_parser_tb;
	import fix_pkg::*;

	`include "fix_ref_model.svh"

	logic   clk;
	logic   arst_n_i;
	logic   word_valid_i;
	word_t  word_i;
	logic   out_credit_i;
	logic   in_credit_o;
	logic   field_valid_o;
	field_t field_o;

	field_t exp_q[$];
	word_t  words[$];
	int     src_credits = FIFO_DEPTH;
	int     out_avail   = FIFO_DEPTH;
	int     rx_count    = 0;
	int     ret_count   = 0;
	int     val_errs    = 0;
	int     cred_errs   = 0;
	int     to_errs     = 0;

	fix_parser_top uut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.word_valid_i  (word_valid_i),
		.word_i        (word_i),
		.out_credit_i  (out_credit_i),
		.in_credit_o   (in_credit_o),
		.field_valid_o (field_valid_o),
		.field_o       (field_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// credits held by the source, and output credits left at the DUT.
	always @(posedge clk) begin
		if (arst_n_i) begin
			if (field_valid_o && out_avail == 0) begin
				$display("ERR %0t: field_valid_o with no output credit", $time);
				cred_errs++;
			end
			out_avail   = out_avail + int'(out_credit_i) - int'(field_valid_o);
			src_credits = src_credits + int'(in_credit_o) - int'(word_valid_i);
			if (src_credits > FIFO_DEPTH) begin
				$display("ERR %0t: source holds %0d credits", $time, src_credits);
				cred_errs++;
			end
		end
	end

	always @(posedge clk) begin : compare
		field_t e;
		if (arst_n_i && field_valid_o) begin
			rx_count++;
			if (exp_q.size() == 0) begin
				$display("ERR %0t: extra field with tag %0d", $time, field_o.tag);
				val_errs++;
			end else begin
				e = exp_q.pop_front();
				if (field_o.tag != e.tag) begin
					$display("ERR %0t: tag %0d, expected %0d", $time, field_o.tag, e.tag);
					val_errs++;
				end
				if (field_o.value != e.value) begin
					$display("ERR %0t: tag %0d value %h, expected %h", $time, e.tag,
						field_o.value, e.value);
					val_errs++;
				end
				if (field_o.len != e.len) begin
					$display("ERR %0t: tag %0d len %0d, expected %0d", $time, e.tag,
						field_o.len, e.len);
					val_errs++;
				end
				if (field_o.trunc != e.trunc) begin
					$display("ERR %0t: tag %0d trunc %b, expected %b", $time, e.tag,
						field_o.trunc, e.trunc);
					val_errs++;
				end
			end
		end
	end

	task automatic wait_src_credit();
		int n;
		n = 0;
		while (src_credits == 0 && n < 2000) begin
			@(posedge clk);
			#0.5;
			n++;
		end
		if (src_credits == 0) begin
			$display("timeout: source waited 2000 cycles for an input credit");
			to_errs++;
		end
	endtask

	// random credit return with long stalls that let the FIFO fill up.
	task automatic return_credits();
		int stall;
		// hold every credit back at first so the FIFO fills.
		stall = 60;
		forever begin
			@(posedge clk);
			#0.5;
			out_credit_i = 1'b0;
			if (stall > 0) begin
				stall--;
			end else if ($urandom % 50 == 0) begin
				stall = 30 + $urandom % 30;
			end else if (rx_count > ret_count && $urandom % 2 == 0) begin
				out_credit_i = 1'b1;
				ret_count++;
			end
		end
	endtask

	initial begin
		string   blk;
		byte_q_t bs;
		int      n;
		int      nexp;
		arst_n_i     = 1'b0;
		word_valid_i = 1'b0;
		word_i       = '0;
		out_credit_i = 1'b0;
		void'($urandom(27));

		// '|' stands for SOH; the block is 26 words long.
		blk = {"8=F|35=AB|49=SENDER|12345=VALUE123456789|9=XY|1A=BAD|7=ZZ|10=QQ|",
			"0000000042=HI|55=12|2=ABCDEFGH|3=ok|Q=1|"};
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < blk.len(); i++) begin
				bs.push_back((blk[i] == 8'h7C) ? SOH_CHAR : blk[i]);
			end
		end
		exp_q = parse_fields(bs);
		nexp  = exp_q.size();
		for (int w = 0; w < bs.size() / BYTES_PER_WORD; w++) begin
			words.push_back({bs[4 * w], bs[4 * w + 1], bs[4 * w + 2], bs[4 * w + 3]});
		end

		repeat (4) @(posedge clk);
		#0.5;
		arst_n_i = 1'b1;
		repeat (8) begin
			@(posedge clk);
			if (field_valid_o !== 1'b0 || in_credit_o !== 1'b0) begin
				$display("ERR %0t: output active before any input", $time);
				cred_errs++;
			end
		end
		#0.5;
		fork
			return_credits();
		join_none

		foreach (words[w]) begin
			if ($urandom % 4 == 0) begin
				@(posedge clk);
				#0.5;
			end
			wait_src_credit();
			if (to_errs != 0) begin
				break;
			end
			word_valid_i = 1'b1;
			word_i       = words[w];
			@(posedge clk);
			#0.5;
			word_valid_i = 1'b0;
		end

		n = 0;
		while ((rx_count != nexp || src_credits != FIFO_DEPTH) && to_errs == 0 &&
			n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (to_errs == 0 && (rx_count != nexp || src_credits != FIFO_DEPTH)) begin
			$display("timeout: %0d of %0d fields seen, source holds %0d credits",
				rx_count, nexp, src_credits);
			to_errs++;
		end
		repeat (10) @(posedge clk);

		$display("value errors %0d, credit errors %0d, timeouts %0d",
			val_errs, cred_errs, to_errs);
		if (val_errs + cred_errs + to_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* src/fix_delim_scan.sv */
`timescale 1ns/100ps
module fix_delim_scan (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           word_valid_i,
	input  fix_pkg::word_t word_i,
	input  logic           status_tag_i,
	input  logic           status_body_i,
	output logic           scan_valid_o,
	output fix_pkg::scan_t scan_o
);
	import fix_pkg::*;

	pos_t  soh_pos;
	pos_t  sep_pos;
	word_t word_q;
	pos_t  soh_q;
	pos_t  sep_q;
	logic  in_tag_q;
	logic  in_body_q;

	// walk from the last byte back so the first match wins.
	always_comb begin
		logic [7:0] b;
		soh_pos = NO_POS;
		sep_pos = NO_POS;
		for (int i = BYTES_PER_WORD - 1; i >= 0; i--) begin
			b = word_i[31 - 8 * i -: 8];
			if (b == SOH_CHAR) begin
				soh_pos = pos_t'(i);
			end
			if (b == SEP_CHAR) begin
				sep_pos = pos_t'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scan_valid_o <= 1'b0;
			in_tag_q     <= 1'b1;
			in_body_q    <= 1'b0;
		end else begin
			scan_valid_o <= word_valid_i;
			if (word_valid_i) begin
				in_tag_q  <= status_tag_i;
				in_body_q <= status_body_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid_i) begin
			word_q <= word_i;
			soh_q  <= soh_pos;
			sep_q  <= sep_pos;
		end
	end

	assign scan_o = '{word: word_q, soh_pos: soh_q, sep_pos: sep_q,
		in_tag: in_tag_q, in_body: in_body_q};

endmodule

/* src/fix_field_assembler.sv */
`timescale 1ns/100ps
module fix_field_assembler (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            frag_valid_i,
	input  fix_pkg::frag_t  frag_i,
	output logic            field_push_o,
	output fix_pkg::field_t field_o,
	output logic            word_done_o,
	output logic            status_tag_o,
	output logic            status_body_o
);
	import fix_pkg::*;

	asm_state_e st, st_n;
	logic       skb, skb_n;
	tag_num_t   tacc, tacc_n;
	logic       tany, tany_n;
	val_t       val, val_n;
	len_t       len, len_n;
	logic       trunc, trunc_n;
	logic       push_n;
	logic       done_n;
	field_t     fld_n;

	function automatic void tag_seg(input logic [31:0] b, input logic [2:0] n,
		inout tag_num_t acc, inout logic any, output logic bad);
		logic [7:0] c;
		bad = 1'b0;
		for (int i = 0; i < BYTES_PER_WORD; i++) begin
			if (i < int'(n)) begin
				c = b[8 * (int'(n) - 1 - i) +: 8];
				if (c >= 8'h30 && c <= 8'h39) begin
					acc = tag_num_t'(acc * 16'd10) + {8'h00, c - 8'h30};
					any = 1'b1;
				end else begin
					bad = 1'b1;
				end
			end
		end
	endfunction

	// shifting keeps the last VAL_MAX_BYTES bytes.
	function automatic void val_seg(input logic [31:0] b, input logic [2:0] n,
		inout val_t v, inout len_t l, inout logic tr);
		for (int i = 0; i < BYTES_PER_WORD; i++) begin
			if (i < int'(n)) begin
				v = {v[55:0], b[8 * (int'(n) - 1 - i) +: 8]};
				if (l == len_t'(VAL_MAX_BYTES)) begin
					tr = 1'b1;
				end else begin
					l = l + 1'b1;
				end
			end
		end
	endfunction

	always_comb begin
		logic [3:0] total;
		logic       two;
		logic       order_a;
		logic       bad;
		st_n    = st;
		skb_n   = skb;
		tacc_n  = tacc;
		tany_n  = tany;
		val_n   = val;
		len_n   = len;
		trunc_n = trunc;
		push_n  = 1'b0;
		done_n  = 1'b0;
		fld_n   = '0;
		bad     = 1'b0;
		total   = {1'b0, frag_i.tag_cnt} + {1'b0, frag_i.body_cnt};
		two     = frag_i.field_end && (total <= 4'd2);
		order_a = two && (st == ST_TAG || (st == ST_SKIP && !skb));

		if (frag_valid_i) begin
			if (!frag_i.field_end) begin
				done_n = 1'b1;
				if (st_n == ST_TAG && frag_i.tag_valid) begin
					tag_seg(frag_i.tag_bytes, frag_i.tag_cnt, tacc_n, tany_n, bad);
					if (bad) begin
						st_n = ST_SKIP;
					end
				end
				// three data bytes with no SOH means an '=' sat in the word.
				if (total == 4'd3) begin
					if (st_n == ST_TAG && tany_n) begin
						st_n = ST_BODY;
					end else begin
						st_n  = ST_SKIP;
						skb_n = 1'b1;
					end
				end
				if (st_n == ST_BODY && frag_i.body_valid) begin
					val_seg(frag_i.body_bytes, frag_i.body_cnt, val_n, len_n, trunc_n);
				end
			end else begin
				if (order_a) begin
					if (!frag_i.tag_status && st_n == ST_TAG) begin
						tag_seg(frag_i.tag_bytes, frag_i.tag_cnt, tacc_n, tany_n, bad);
						if (bad) begin
							st_n = ST_SKIP;
						end
					end
					st_n = (st_n == ST_TAG && tany_n) ? ST_BODY : ST_SKIP;
				end
				if (st_n == ST_BODY && !(two && frag_i.body_status)) begin
					val_seg(frag_i.body_bytes, frag_i.body_cnt, val_n, len_n, trunc_n);
				end

				// the SOH closes the field.
				push_n = (st_n == ST_BODY);
				done_n = !push_n;
				fld_n  = '{tag: tacc_n, value: val_n, len: len_n, trunc: trunc_n};
				st_n    = ST_TAG;
				skb_n   = 1'b0;
				tacc_n  = '0;
				tany_n  = 1'b0;
				val_n   = '0;
				len_n   = '0;
				trunc_n = 1'b0;

				if (frag_i.tag_status) begin
					tag_seg(frag_i.tag_bytes, frag_i.tag_cnt, tacc_n, tany_n, bad);
					if (bad) begin
						st_n = ST_SKIP;
					end
				end
				if (two && !order_a) begin
					if (st_n == ST_TAG && tany_n) begin
						st_n = ST_BODY;
					end else begin
						st_n  = ST_SKIP;
						skb_n = 1'b1;
					end
					if (st_n == ST_BODY && frag_i.body_status) begin
						val_seg(frag_i.body_bytes, frag_i.body_cnt, val_n, len_n, trunc_n);
					end
				end
			end
		end
	end

	// status for the next word is valid in the same cycle for back-to-back words.
	assign status_tag_o  = (st_n == ST_TAG) || (st_n == ST_SKIP && !skb_n);
	assign status_body_o = !status_tag_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			st           <= ST_TAG;
			skb          <= 1'b0;
			tacc         <= '0;
			tany         <= 1'b0;
			val          <= '0;
			len          <= '0;
			trunc        <= 1'b0;
			field_push_o <= 1'b0;
			word_done_o  <= 1'b0;
		end else begin
			st           <= st_n;
			skb          <= skb_n;
			tacc         <= tacc_n;
			tany         <= tany_n;
			val          <= val_n;
			len          <= len_n;
			trunc        <= trunc_n;
			field_push_o <= push_n;
			word_done_o  <= done_n;
		end
	end

	always_ff @(posedge clk) begin
		if (push_n) begin
			field_o <= fld_n;
		end
	end

endmodule

/* src/fix_field_fifo.sv */
`timescale 1ns/100ps
module fix_field_fifo (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            push_i,
	input  fix_pkg::field_t field_i,
	input  logic            word_done_i,
	input  logic            out_credit_i,
	output logic            field_valid_o,
	output fix_pkg::field_t field_o,
	output logic            in_credit_o
);
	import fix_pkg::*;

	field_t                          mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
	cnt_t                            count;
	cnt_t                            credits;
	cnt_t                            pending;
	cnt_t                            pend_sum;
	logic                            pop;
	logic                            ret_n;

	// a field leaves only when the consumer has room for it.
	assign pop = (count != '0) && (credits != '0);

	assign pend_sum = pending + cnt_t'(pop) + cnt_t'(word_done_i);
	assign ret_n    = (pend_sum != '0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credits       <= cnt_t'(FIFO_DEPTH);
			pending       <= '0;
			field_valid_o <= 1'b0;
			in_credit_o   <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count         <= count + cnt_t'(push_i) - cnt_t'(pop);
			credits       <= credits + cnt_t'(out_credit_i) - cnt_t'(pop);
			pending       <= pend_sum - cnt_t'(ret_n);
			field_valid_o <= pop;
			in_credit_o   <= ret_n;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= field_i;
		end
		if (pop) begin
			field_o <= mem[rd_ptr];
		end
	end

endmodule

/* src/fix_parser_out_module.sv */
`timescale 1ns/100ps
module fix_parser_out_module (
	input  fix_pkg::scan_t scan_i,
	output fix_pkg::frag_t frag_o
);
	import fix_pkg::*;

	int   s;
	int   p;
	logic has_soh;
	logic has_sep;

	// bytes first..first+cnt-1 of the word, right-aligned.
	function automatic logic [31:0] take(input word_t w, input int first, input int cnt);
		logic [31:0] t;
		t = w << (8 * first);
		if (cnt <= 0) begin
			return '0;
		end
		return t >> (8 * (BYTES_PER_WORD - cnt));
	endfunction

	assign s       = int'(scan_i.soh_pos);
	assign p       = int'(scan_i.sep_pos);
	assign has_soh = (scan_i.soh_pos != NO_POS);
	assign has_sep = (scan_i.sep_pos != NO_POS);

	always_comb begin
		frag_o = '0;

		if (has_soh && has_sep) begin
			frag_o.field_end = 1'b1;
			if (p < s) begin
				// tag end, '=', value, SOH, new tag.
				frag_o.body_bytes = take(scan_i.word, p + 1, s - p - 1);
				frag_o.body_cnt   = 3'(s - p - 1);
				if (p != 0) begin
					frag_o.tag_bytes = take(scan_i.word, 0, p);
					frag_o.tag_cnt   = 3'(p);
				end else begin
					frag_o.tag_bytes  = take(scan_i.word, s + 1, 3 - s);
					frag_o.tag_cnt    = 3'(3 - s);
					frag_o.tag_status = 1'b1;
				end
			end else begin
				// value end, SOH, new tag, '=', new value.
				frag_o.tag_bytes  = take(scan_i.word, s + 1, p - s - 1);
				frag_o.tag_cnt    = 3'(p - s - 1);
				frag_o.tag_status = 1'b1;
				if (s != 0) begin
					frag_o.body_bytes = take(scan_i.word, 0, s);
					frag_o.body_cnt   = 3'(s);
				end else begin
					frag_o.body_bytes  = take(scan_i.word, p + 1, 3 - p);
					frag_o.body_cnt    = 3'(3 - p);
					frag_o.body_status = 1'b1;
				end
			end
		end else if (has_soh) begin
			frag_o.field_end  = 1'b1;
			frag_o.body_bytes = take(scan_i.word, 0, s);
			frag_o.body_cnt   = 3'(s);
			frag_o.tag_bytes  = take(scan_i.word, s + 1, 3 - s);
			frag_o.tag_cnt    = 3'(3 - s);
			frag_o.tag_status = 1'b1;
		end else if (has_sep) begin
			frag_o.tag_bytes   = take(scan_i.word, 0, p);
			frag_o.tag_cnt     = 3'(p);
			frag_o.body_bytes  = take(scan_i.word, p + 1, 3 - p);
			frag_o.body_cnt    = 3'(3 - p);
			frag_o.body_status = 1'b1;
		end else if (scan_i.in_tag) begin
			frag_o.tag_bytes  = scan_i.word;
			frag_o.tag_cnt    = 3'(BYTES_PER_WORD);
			frag_o.tag_status = 1'b1;
		end else if (scan_i.in_body) begin
			frag_o.body_bytes  = scan_i.word;
			frag_o.body_cnt    = 3'(BYTES_PER_WORD);
			frag_o.body_status = 1'b1;
		end

		frag_o.tag_valid  = (frag_o.tag_cnt != 3'd0);
		frag_o.body_valid = (frag_o.body_cnt != 3'd0);
	end

endmodule

/* src/fix_parser_top.sv */
`timescale 1ns/100ps
module fix_parser_top (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            word_valid_i,
	input  fix_pkg::word_t  word_i,
	input  logic            out_credit_i,
	output logic            in_credit_o,
	output logic            field_valid_o,
	output fix_pkg::field_t field_o
);
	import fix_pkg::*;

	scan_t  scan;
	logic   scan_valid;
	frag_t  frag;
	field_t field;
	logic   field_push;
	logic   word_done;
	logic   status_tag;
	logic   status_body;

	fix_delim_scan u_scan (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.word_valid_i  (word_valid_i),
		.word_i        (word_i),
		.status_tag_i  (status_tag),
		.status_body_i (status_body),
		.scan_valid_o  (scan_valid),
		.scan_o        (scan)
	);

	fix_parser_out_module u_split (
		.scan_i (scan),
		.frag_o (frag)
	);

	fix_field_assembler u_asm (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.frag_valid_i  (scan_valid),
		.frag_i        (frag),
		.field_push_o  (field_push),
		.field_o       (field),
		.word_done_o   (word_done),
		.status_tag_o  (status_tag),
		.status_body_o (status_body)
	);

	fix_field_fifo u_fifo (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.push_i        (field_push),
		.field_i       (field),
		.word_done_i   (word_done),
		.out_credit_i  (out_credit_i),
		.field_valid_o (field_valid_o),
		.field_o       (field_o),
		.in_credit_o   (in_credit_o)
	);

endmodule

/* src/fix_pkg.sv */
package fix_pkg;

	typedef logic [31:0] word_t;
	typedef logic [2:0]  pos_t;
	typedef logic [15:0] tag_num_t;
	typedef logic [63:0] val_t;
	typedef logic [3:0]  len_t;
	typedef logic [3:0]  cnt_t;

	localparam int       BYTES_PER_WORD = 4;
	localparam logic [7:0] SOH_CHAR     = 8'h01;
	localparam logic [7:0] SEP_CHAR     = 8'h3D;
	localparam pos_t     NO_POS         = 3'd7;
	localparam int       VAL_MAX_BYTES  = 8;
	localparam int       FIFO_DEPTH     = 8;

	// one registered input word with its delimiter positions.
	typedef struct packed {
		word_t word;
		pos_t  soh_pos;
		pos_t  sep_pos;
		logic  in_tag;
		logic  in_body;
	} scan_t;

	// tag_status marks tag bytes that lie after the SOH.
	// body_status marks body bytes that lie after an '=' which follows the SOH.
	typedef struct packed {
		logic [31:0] tag_bytes;
		logic [31:0] body_bytes;
		logic [2:0]  tag_cnt;
		logic [2:0]  body_cnt;
		logic        tag_valid;
		logic        body_valid;
		logic        tag_status;
		logic        body_status;
		logic        field_end;
	} frag_t;

	typedef struct packed {
		tag_num_t tag;
		val_t     value;
		len_t     len;
		logic     trunc;
	} field_t;

	typedef enum logic [1:0] {
		ST_TAG,
		ST_BODY,
		ST_SKIP
	} asm_state_e;

endpackage
